// File: Makefile
TOP = vlane_tb

.PHONY: sim clean

# $fatal in the testbench gives a non-zero exit status
sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: build.f
+incdir+include
hw/vlane_op_pkg.sv
hw/vlane_data_pkg.sv
hw/vlane_decode.sv
hw/vlane_arith.sv
hw/vlane_writeback.sv
hw/vlane_top.sv
tests/vlane_tb.sv

// File: hw/vlane_arith.sv
/*
 * Stage 2 of the lane pipeline.
 * Element ALU with compares, min/max, extension, carry arithmetic and the
 * reduction accumulator. The result is registered for writeback.
 */
`timescale 1ns/1ps

module vlane_arith (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   d_valid,
  input  vlane_op_pkg::alu_op_t  d_aluop,
  input  vlane_op_pkg::comp_t    d_comp_type,
  input  vlane_op_pkg::minmax_t  d_minmax_type,
  input  vlane_op_pkg::ext_t     d_ext_type,
  input  vlane_op_pkg::result_t  d_result_type,
  input  logic                   d_carryin_ena,
  input  logic                   d_adc_sbc,
  input  logic                   d_carry_borrow_ena,
  input  logic                   d_rev,
  input  logic                   d_reduction_ena,
  input  vlane_op_pkg::sew_t     d_sew,
  input  logic                   d_mask,
  input  logic                   d_active,
  input  vlane_data_pkg::idx_t   d_index,
  input  vlane_data_pkg::elem_t  d_vs1,
  input  vlane_data_pkg::elem_t  d_vs2,
  input  vlane_data_pkg::elem_t  d_vs3,
  output logic                   a_valid,
  output vlane_data_pkg::elem_t  a_result,
  output vlane_op_pkg::sew_t     a_sew,
  output logic                   a_active,
  output vlane_data_pkg::idx_t   a_index,
  output vlane_data_pkg::elem_t  a_vs3,
  output logic                   a_is_mask
);

  vlane_data_pkg::elem_t accumulator;
  vlane_data_pkg::elem_t src1, op_a, op_b;
  vlane_data_pkg::elem_t sew_mask, cmp1, cmp2, srl_src, sra_src;
  vlane_data_pkg::elem_t f2z, f2s, f4z, f4s, f8z, f8s, ext, mm, op3res, final_result;
  vlane_data_pkg::wide_t result, as_res;
  logic [4:0]            shamt;
  logic                  msb1, msb2, sltu, slt, seq, comp, carryin;

  // Reductions past the first element fold into the running value
  assign src1 = (d_reduction_ena && d_index != '0) ? accumulator : d_vs1;
  assign op_a = d_rev ? src1 : d_vs2;
  assign op_b = d_rev ? d_vs2 : src1;

  // SEW dependent views of the operands
  always_comb begin
    case (d_sew)
      vlane_op_pkg::SEW8: begin
        sew_mask = 32'h0000_00ff;
        shamt    = {2'b00, src1[2:0]};
        sra_src  = {{24{d_vs2[7]}}, d_vs2[7:0]};
        f2z      = {28'd0, d_vs2[3:0]};
        f4z      = {30'd0, d_vs2[1:0]};
        f8z      = {31'd0, d_vs2[0]};
        f2s      = {{28{d_vs2[3]}}, d_vs2[3:0]};
        f4s      = {{30{d_vs2[1]}}, d_vs2[1:0]};
        f8s      = {32{d_vs2[0]}};
      end
      vlane_op_pkg::SEW16: begin
        sew_mask = 32'h0000_ffff;
        shamt    = {1'b0, src1[3:0]};
        sra_src  = {{16{d_vs2[15]}}, d_vs2[15:0]};
        f2z      = {24'd0, d_vs2[7:0]};
        f4z      = {28'd0, d_vs2[3:0]};
        f8z      = {30'd0, d_vs2[1:0]};
        f2s      = {{24{d_vs2[7]}}, d_vs2[7:0]};
        f4s      = {{28{d_vs2[3]}}, d_vs2[3:0]};
        f8s      = {{30{d_vs2[1]}}, d_vs2[1:0]};
      end
      default: begin
        sew_mask = 32'hffff_ffff;
        shamt    = src1[4:0];
        sra_src  = d_vs2;
        f2z      = {16'd0, d_vs2[15:0]};
        f4z      = {24'd0, d_vs2[7:0]};
        f8z      = {28'd0, d_vs2[3:0]};
        f2s      = {{16{d_vs2[15]}}, d_vs2[15:0]};
        f4s      = {{24{d_vs2[7]}}, d_vs2[7:0]};
        f8s      = {{28{d_vs2[3]}}, d_vs2[3:0]};
      end
    endcase
  end

  // Compare on the low SEW bits only, vs2 against vs1
  assign cmp1    = src1 & sew_mask;
  assign cmp2    = d_vs2 & sew_mask;
  assign srl_src = cmp2;
  assign msb1    = cmp1[31] | (d_sew == vlane_op_pkg::SEW8  && cmp1[7]) |
                   (d_sew == vlane_op_pkg::SEW16 && cmp1[15]);
  assign msb2    = cmp2[31] | (d_sew == vlane_op_pkg::SEW8  && cmp2[7]) |
                   (d_sew == vlane_op_pkg::SEW16 && cmp2[15]);
  assign sltu    = cmp2 < cmp1;
  assign slt     = (msb1 != msb2) ? msb2 : sltu;
  assign seq     = cmp1 == cmp2;

  always_comb begin
    case (d_comp_type)
      vlane_op_pkg::CMP_SEQ:  comp = seq;
      vlane_op_pkg::CMP_SNE:  comp = !seq;
      vlane_op_pkg::CMP_SLTU: comp = sltu;
      vlane_op_pkg::CMP_SLT:  comp = slt;
      vlane_op_pkg::CMP_SLEU: comp = sltu | seq;
      vlane_op_pkg::CMP_SLE:  comp = slt | seq;
      vlane_op_pkg::CMP_SGTU: comp = !(sltu | seq);
      default:                comp = !(slt | seq);
    endcase
    case (d_minmax_type)
      vlane_op_pkg::MIN:  mm = slt ? d_vs2 : src1;
      vlane_op_pkg::MINU: mm = sltu ? d_vs2 : src1;
      vlane_op_pkg::MAX:  mm = slt ? src1 : d_vs2;
      default:            mm = sltu ? src1 : d_vs2;
    endcase
    case (d_ext_type)
      vlane_op_pkg::F2Z: ext = f2z;
      vlane_op_pkg::F2S: ext = f2s;
      vlane_op_pkg::F4Z: ext = f4z;
      vlane_op_pkg::F4S: ext = f4s;
      vlane_op_pkg::F8Z: ext = f8z;
      default:           ext = f8s;
    endcase
  end

  // Main ALU, 33 bits wide so add and subtract keep their carry
  always_comb begin
    case (d_aluop)
      vlane_op_pkg::ALU_SLL:   result = {1'b0, d_vs2 << shamt};
      vlane_op_pkg::ALU_SRL:   result = {1'b0, srl_src >> shamt};
      vlane_op_pkg::ALU_SRA:   result = {1'b0, $signed(sra_src) >>> shamt};
      vlane_op_pkg::ALU_ADD:   result = {1'b0, op_a} + {1'b0, op_b};
      vlane_op_pkg::ALU_SUB:   result = {1'b0, op_a} - {1'b0, op_b};
      vlane_op_pkg::ALU_AND:   result = {1'b0, d_vs2 & src1};
      vlane_op_pkg::ALU_OR:    result = {1'b0, d_vs2 | src1};
      vlane_op_pkg::ALU_XOR:   result = {1'b0, d_vs2 ^ src1};
      vlane_op_pkg::ALU_COMP:  result = {32'd0, comp};
      vlane_op_pkg::ALU_MERGE: result = {1'b0, d_mask ? src1 : d_vs2};
      vlane_op_pkg::ALU_MOVE:  result = {1'b0, src1};
      vlane_op_pkg::ALU_MM:    result = {1'b0, mm};
      default:                 result = {1'b0, ext};
    endcase
  end

  // Carry-in comes from the mask bit
  assign carryin = d_carryin_ena & d_mask;
  assign as_res  = d_adc_sbc ? result + carryin : result - carryin;
  assign op3res  = d_carry_borrow_ena ? {31'd0, as_res[32]} : as_res[31:0];
  assign final_result = (d_result_type == vlane_op_pkg::A_S) ? op3res : result[31:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      accumulator <= '0;
      a_valid     <= 1'b0;
      a_sew       <= vlane_op_pkg::SEW8;
      a_active    <= 1'b0;
      a_is_mask   <= 1'b0;
    end else begin
      if (d_valid && d_reduction_ena) begin
        accumulator <= final_result;
      end
      a_valid   <= d_valid;
      a_sew     <= d_sew;
      a_active  <= d_active;
      a_is_mask <= (d_aluop == vlane_op_pkg::ALU_COMP) | d_carry_borrow_ena;
    end
  end

  always_ff @(posedge CLK) begin
    a_result <= final_result;
    a_index  <= d_index;
    a_vs3    <= d_vs3;
  end

endmodule

// File: hw/vlane_data_pkg.sv
/*
 * Data widths for the vector lane.
 * Element, carry-extended result and element index types.
 */
`include "vlane_macros.svh"

package vlane_data_pkg;

  // One element operand or result
  typedef logic [`VLANE_ELEN-1:0] elem_t;

  // Result with its carry or borrow bit on top
  typedef logic [`VLANE_ELEN:0] wide_t;

  // Position of the element in the vector
  typedef logic [`VLANE_IDX_W-1:0] idx_t;

endpackage

// File: hw/vlane_decode.sv
/*
 * Stage 1 of the lane pipeline.
 * Registers the incoming element and expands its opcode into ALU controls.
 */
`timescale 1ns/1ps

module vlane_decode (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  input  vlane_op_pkg::vop_t     vop,
  input  vlane_op_pkg::sew_t     sew,
  input  logic                   vm,
  input  logic                   mask,
  input  vlane_data_pkg::idx_t   index,
  input  vlane_data_pkg::elem_t  vs1_data,
  input  vlane_data_pkg::elem_t  vs2_data,
  input  vlane_data_pkg::elem_t  vs3_data,
  output logic                   d_valid,
  output vlane_op_pkg::alu_op_t  d_aluop,
  output vlane_op_pkg::comp_t    d_comp_type,
  output vlane_op_pkg::minmax_t  d_minmax_type,
  output vlane_op_pkg::ext_t     d_ext_type,
  output vlane_op_pkg::result_t  d_result_type,
  output logic                   d_carryin_ena,
  output logic                   d_adc_sbc,
  output logic                   d_carry_borrow_ena,
  output logic                   d_rev,
  output logic                   d_reduction_ena,
  output vlane_op_pkg::sew_t     d_sew,
  output logic                   d_mask,
  output logic                   d_active,
  output vlane_data_pkg::idx_t   d_index,
  output vlane_data_pkg::elem_t  d_vs1,
  output vlane_data_pkg::elem_t  d_vs2,
  output vlane_data_pkg::elem_t  d_vs3
);

  vlane_op_pkg::alu_op_t  aluop;
  vlane_op_pkg::comp_t    comp_type;
  vlane_op_pkg::minmax_t  minmax_type;
  vlane_op_pkg::ext_t     ext_type;
  logic                   carryin_ena;
  logic                   carry_borrow_ena;
  logic                   adc_sbc;
  logic                   reduction_ena;
  logic                   active;

  // Main ALU operation per opcode
  always_comb begin
    case (vop)
      vlane_op_pkg::VOP_SUB, vlane_op_pkg::VOP_RSUB,
      vlane_op_pkg::VOP_SBC, vlane_op_pkg::VOP_MSBC:   aluop = vlane_op_pkg::ALU_SUB;
      vlane_op_pkg::VOP_AND, vlane_op_pkg::VOP_REDAND: aluop = vlane_op_pkg::ALU_AND;
      vlane_op_pkg::VOP_OR, vlane_op_pkg::VOP_REDOR:   aluop = vlane_op_pkg::ALU_OR;
      vlane_op_pkg::VOP_XOR, vlane_op_pkg::VOP_REDXOR: aluop = vlane_op_pkg::ALU_XOR;
      vlane_op_pkg::VOP_SLL:                           aluop = vlane_op_pkg::ALU_SLL;
      vlane_op_pkg::VOP_SRL:                           aluop = vlane_op_pkg::ALU_SRL;
      vlane_op_pkg::VOP_SRA:                           aluop = vlane_op_pkg::ALU_SRA;
      vlane_op_pkg::VOP_MSEQ, vlane_op_pkg::VOP_MSNE,
      vlane_op_pkg::VOP_MSLTU, vlane_op_pkg::VOP_MSLT,
      vlane_op_pkg::VOP_MSLEU, vlane_op_pkg::VOP_MSLE,
      vlane_op_pkg::VOP_MSGTU, vlane_op_pkg::VOP_MSGT: aluop = vlane_op_pkg::ALU_COMP;
      vlane_op_pkg::VOP_MINU, vlane_op_pkg::VOP_MIN,
      vlane_op_pkg::VOP_MAXU, vlane_op_pkg::VOP_MAX,
      vlane_op_pkg::VOP_REDMAX, vlane_op_pkg::VOP_REDMIN: aluop = vlane_op_pkg::ALU_MM;
      vlane_op_pkg::VOP_MERGE:                         aluop = vlane_op_pkg::ALU_MERGE;
      vlane_op_pkg::VOP_MV:                            aluop = vlane_op_pkg::ALU_MOVE;
      vlane_op_pkg::VOP_ZEXT2, vlane_op_pkg::VOP_SEXT2,
      vlane_op_pkg::VOP_ZEXT4, vlane_op_pkg::VOP_SEXT4,
      vlane_op_pkg::VOP_ZEXT8, vlane_op_pkg::VOP_SEXT8: aluop = vlane_op_pkg::ALU_EXT;
      default:                                         aluop = vlane_op_pkg::ALU_ADD;
    endcase
  end

  // Sub-selectors, don't care outside their own ALU operation
  always_comb begin
    case (vop)
      vlane_op_pkg::VOP_MSNE:  comp_type = vlane_op_pkg::CMP_SNE;
      vlane_op_pkg::VOP_MSLTU: comp_type = vlane_op_pkg::CMP_SLTU;
      vlane_op_pkg::VOP_MSLT:  comp_type = vlane_op_pkg::CMP_SLT;
      vlane_op_pkg::VOP_MSLEU: comp_type = vlane_op_pkg::CMP_SLEU;
      vlane_op_pkg::VOP_MSLE:  comp_type = vlane_op_pkg::CMP_SLE;
      vlane_op_pkg::VOP_MSGTU: comp_type = vlane_op_pkg::CMP_SGTU;
      vlane_op_pkg::VOP_MSGT:  comp_type = vlane_op_pkg::CMP_SGT;
      default:                 comp_type = vlane_op_pkg::CMP_SEQ;
    endcase
    case (vop)
      vlane_op_pkg::VOP_MINU:  minmax_type = vlane_op_pkg::MINU;
      vlane_op_pkg::VOP_MAXU:  minmax_type = vlane_op_pkg::MAXU;
      vlane_op_pkg::VOP_MAX,
      vlane_op_pkg::VOP_REDMAX: minmax_type = vlane_op_pkg::MAX;
      default:                 minmax_type = vlane_op_pkg::MIN;
    endcase
    case (vop)
      vlane_op_pkg::VOP_SEXT2: ext_type = vlane_op_pkg::F2S;
      vlane_op_pkg::VOP_ZEXT4: ext_type = vlane_op_pkg::F4Z;
      vlane_op_pkg::VOP_SEXT4: ext_type = vlane_op_pkg::F4S;
      vlane_op_pkg::VOP_ZEXT8: ext_type = vlane_op_pkg::F8Z;
      vlane_op_pkg::VOP_SEXT8: ext_type = vlane_op_pkg::F8S;
      default:                 ext_type = vlane_op_pkg::F2Z;
    endcase
  end

  assign carryin_ena = vop inside {vlane_op_pkg::VOP_ADC, vlane_op_pkg::VOP_SBC,
                                   vlane_op_pkg::VOP_MADC, vlane_op_pkg::VOP_MSBC};
  assign carry_borrow_ena = vop inside {vlane_op_pkg::VOP_MADC, vlane_op_pkg::VOP_MSBC};
  assign adc_sbc = vop inside {vlane_op_pkg::VOP_ADC, vlane_op_pkg::VOP_MADC};
  assign reduction_ena = vop inside {vlane_op_pkg::VOP_REDSUM, vlane_op_pkg::VOP_REDMAX,
                                     vlane_op_pkg::VOP_REDMIN, vlane_op_pkg::VOP_REDAND,
                                     vlane_op_pkg::VOP_REDOR, vlane_op_pkg::VOP_REDXOR};

  // Merge and the carry forms consume the mask as data, so they always write
  assign active = vm | mask | carryin_ena | (vop == vlane_op_pkg::VOP_MERGE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      d_valid            <= 1'b0;
      d_aluop            <= vlane_op_pkg::ALU_SLL;
      d_comp_type        <= vlane_op_pkg::CMP_SEQ;
      d_minmax_type      <= vlane_op_pkg::MIN;
      d_ext_type         <= vlane_op_pkg::F2Z;
      d_result_type      <= vlane_op_pkg::NORMAL;
      d_carryin_ena      <= 1'b0;
      d_adc_sbc          <= 1'b0;
      d_carry_borrow_ena <= 1'b0;
      d_rev              <= 1'b0;
      d_reduction_ena    <= 1'b0;
      d_sew              <= vlane_op_pkg::SEW8;
      d_active           <= 1'b0;
    end else begin
      d_valid            <= in_valid;
      d_aluop            <= aluop;
      d_comp_type        <= comp_type;
      d_minmax_type      <= minmax_type;
      d_ext_type         <= ext_type;
      d_result_type      <= carryin_ena ? vlane_op_pkg::A_S : vlane_op_pkg::NORMAL;
      d_carryin_ena      <= carryin_ena;
      d_adc_sbc          <= adc_sbc;
      d_carry_borrow_ena <= carry_borrow_ena;
      d_rev              <= (vop == vlane_op_pkg::VOP_RSUB);
      d_reduction_ena    <= reduction_ena;
      d_sew              <= sew;
      d_active           <= active;
    end
  end

  // Operand payload
  always_ff @(posedge CLK) begin
    d_mask  <= mask;
    d_index <= index;
    d_vs1   <= vs1_data;
    d_vs2   <= vs2_data;
    d_vs3   <= vs3_data;
  end

endmodule

// File: hw/vlane_op_pkg.sv
/*
 * Operation encodings for the vector lane.
 * Opcodes, SEW and the internal ALU selectors shared by all stages.
 */
package vlane_op_pkg;

  // Lane opcode as seen at the lane input
  typedef enum logic [5:0] {
    VOP_ADD, VOP_SUB, VOP_RSUB,
    VOP_AND, VOP_OR, VOP_XOR,
    VOP_SLL, VOP_SRL, VOP_SRA,
    VOP_MSEQ, VOP_MSNE, VOP_MSLTU, VOP_MSLT,
    VOP_MSLEU, VOP_MSLE, VOP_MSGTU, VOP_MSGT,
    VOP_MINU, VOP_MIN, VOP_MAXU, VOP_MAX,
    VOP_MERGE, VOP_MV,
    VOP_ZEXT2, VOP_SEXT2, VOP_ZEXT4, VOP_SEXT4, VOP_ZEXT8, VOP_SEXT8,
    VOP_ADC, VOP_SBC, VOP_MADC, VOP_MSBC,
    VOP_REDSUM, VOP_REDMAX, VOP_REDMIN, VOP_REDAND, VOP_REDOR, VOP_REDXOR
  } vop_t;

  typedef enum logic [1:0] {
    SEW8, SEW16, SEW32
  } sew_t;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_COMP, ALU_MERGE, ALU_MOVE, ALU_MM, ALU_EXT
  } alu_op_t;

  typedef enum logic [2:0] {
    CMP_SEQ, CMP_SNE, CMP_SLTU, CMP_SLT,
    CMP_SLEU, CMP_SLE, CMP_SGTU, CMP_SGT
  } comp_t;

  typedef enum logic [1:0] {
    MIN, MINU, MAX, MAXU
  } minmax_t;

  // Fraction and kind of the extension source
  typedef enum logic [2:0] {
    F2Z, F2S, F4Z, F4S, F8Z, F8S
  } ext_t;

  // A_S picks the carry-adjusted result
  typedef enum logic {
    NORMAL, A_S
  } result_t;

endpackage

// File: hw/vlane_top.sv
/*
 * Vector lane top level.
 * Decode, arithmetic and writeback in a fixed three-cycle pipeline,
 * one element in per cycle with no back-pressure.
 */
`timescale 1ns/1ps

module vlane_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  input  vlane_op_pkg::vop_t     vop,
  input  vlane_op_pkg::sew_t     sew,
  input  logic                   vm,
  input  logic                   mask,
  input  vlane_data_pkg::idx_t   index,
  input  vlane_data_pkg::elem_t  vs1_data,
  input  vlane_data_pkg::elem_t  vs2_data,
  input  vlane_data_pkg::elem_t  vs3_data,
  output logic                   out_valid,
  output vlane_data_pkg::elem_t  out_data,
  output vlane_data_pkg::idx_t   out_index
);

  // Decode to arithmetic
  logic                   d_valid, d_carryin_ena, d_adc_sbc, d_carry_borrow_ena;
  logic                   d_rev, d_reduction_ena, d_mask, d_active;
  vlane_op_pkg::alu_op_t  d_aluop;
  vlane_op_pkg::comp_t    d_comp_type;
  vlane_op_pkg::minmax_t  d_minmax_type;
  vlane_op_pkg::ext_t     d_ext_type;
  vlane_op_pkg::result_t  d_result_type;
  vlane_op_pkg::sew_t     d_sew;
  vlane_data_pkg::idx_t   d_index;
  vlane_data_pkg::elem_t  d_vs1, d_vs2, d_vs3;

  // Arithmetic to writeback
  logic                   a_valid, a_active, a_is_mask;
  vlane_data_pkg::elem_t  a_result, a_vs3;
  vlane_op_pkg::sew_t     a_sew;
  vlane_data_pkg::idx_t   a_index;

  vlane_decode i_vlane_decode (.*);

  vlane_arith i_vlane_arith (.*);

  vlane_writeback i_vlane_writeback (.*);

endmodule

// File: hw/vlane_writeback.sv
/*
 * Stage 3 of the lane pipeline.
 * Applies masking and SEW truncation, then registers the lane output.
 */
`timescale 1ns/1ps

module vlane_writeback (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   a_valid,
  input  vlane_data_pkg::elem_t  a_result,
  input  vlane_op_pkg::sew_t     a_sew,
  input  logic                   a_active,
  input  vlane_data_pkg::idx_t   a_index,
  input  vlane_data_pkg::elem_t  a_vs3,
  input  logic                   a_is_mask,
  output logic                   out_valid,
  output vlane_data_pkg::elem_t  out_data,
  output vlane_data_pkg::idx_t   out_index
);

  vlane_data_pkg::elem_t sew_mask;
  vlane_data_pkg::elem_t wb_data;

  always_comb begin
    case (a_sew)
      vlane_op_pkg::SEW8:  sew_mask = 32'h0000_00ff;
      vlane_op_pkg::SEW16: sew_mask = 32'h0000_ffff;
      default:             sew_mask = 32'hffff_ffff;
    endcase
  end

  // Inactive elements keep the old destination
  // Mask results are single bits and skip truncation
  assign wb_data = !a_active ? a_vs3 :
                   a_is_mask ? a_result :
                   (a_result & sew_mask);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= a_valid;
      if (a_valid) begin
        out_data <= wb_data;
      end
    end
  end

  always_ff @(posedge CLK) begin
    out_index <= a_index;
  end

endmodule

// File: include/vlane_macros.svh
/*
 * Global sizing for the vector lane.
 * Include wherever element width, index width or latency is needed.
 */
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

// Element width in bits
`define VLANE_ELEN 32

// Element index width
`define VLANE_IDX_W 5

// Input to output latency in cycles
`define VLANE_DEPTH 3

`endif

// File: tests/vlane_tb.sv
/*
 * Testbench for the vector lane top level.
 * Drives element operations, predicts each output with a model and
 * compares data, index and latency as results leave the pipeline.
 */
`timescale 1ns/1ps
`include "vlane_macros.svh"

module vlane_tb;

  localparam int PERIOD = 20;
  // Upper bound on elements driven by all tests
  localparam int N_ELEMS = 8 + 300 + 900 + 72 + 24 + 96 + 50 + 192;
  localparam int MAX_CYCLES = 4 + N_ELEMS + `VLANE_DEPTH + 64;

  logic                  CLK;
  logic                  nRST;
  logic                  in_valid;
  vlane_op_pkg::vop_t    vop;
  vlane_op_pkg::sew_t    sew;
  logic                  vm;
  logic                  mask;
  vlane_data_pkg::idx_t  index;
  vlane_data_pkg::elem_t vs1_data;
  vlane_data_pkg::elem_t vs2_data;
  vlane_data_pkg::elem_t vs3_data;
  logic                  out_valid;
  vlane_data_pkg::elem_t out_data;
  vlane_data_pkg::idx_t  out_index;

  // Expected results in issue order
  vlane_data_pkg::elem_t exp_data[$];
  vlane_data_pkg::idx_t  exp_index[$];
  time                   exp_time[$];
  vlane_data_pkg::elem_t model_acc;

  vlane_op_pkg::vop_t alu_ops[10] = '{
    vlane_op_pkg::VOP_ADD, vlane_op_pkg::VOP_SUB, vlane_op_pkg::VOP_RSUB,
    vlane_op_pkg::VOP_AND, vlane_op_pkg::VOP_OR, vlane_op_pkg::VOP_XOR,
    vlane_op_pkg::VOP_SLL, vlane_op_pkg::VOP_SRL, vlane_op_pkg::VOP_SRA,
    vlane_op_pkg::VOP_MV};
  vlane_op_pkg::vop_t cmp_ops[12] = '{
    vlane_op_pkg::VOP_MSEQ, vlane_op_pkg::VOP_MSNE, vlane_op_pkg::VOP_MSLTU,
    vlane_op_pkg::VOP_MSLT, vlane_op_pkg::VOP_MSLEU, vlane_op_pkg::VOP_MSLE,
    vlane_op_pkg::VOP_MSGTU, vlane_op_pkg::VOP_MSGT, vlane_op_pkg::VOP_MINU,
    vlane_op_pkg::VOP_MIN, vlane_op_pkg::VOP_MAXU, vlane_op_pkg::VOP_MAX};
  vlane_op_pkg::vop_t ext_ops[6] = '{
    vlane_op_pkg::VOP_ZEXT2, vlane_op_pkg::VOP_SEXT2, vlane_op_pkg::VOP_ZEXT4,
    vlane_op_pkg::VOP_SEXT4, vlane_op_pkg::VOP_ZEXT8, vlane_op_pkg::VOP_SEXT8};
  vlane_op_pkg::vop_t carry_ops[4] = '{
    vlane_op_pkg::VOP_ADC, vlane_op_pkg::VOP_SBC,
    vlane_op_pkg::VOP_MADC, vlane_op_pkg::VOP_MSBC};
  vlane_op_pkg::vop_t red_ops[6] = '{
    vlane_op_pkg::VOP_REDSUM, vlane_op_pkg::VOP_REDMAX, vlane_op_pkg::VOP_REDMIN,
    vlane_op_pkg::VOP_REDAND, vlane_op_pkg::VOP_REDOR, vlane_op_pkg::VOP_REDXOR};

  vlane_top i_vlane_top (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  function automatic vlane_data_pkg::elem_t lane_mask(input vlane_op_pkg::sew_t s);
    return (s == vlane_op_pkg::SEW8) ? 32'h0000_00ff :
           (s == vlane_op_pkg::SEW16) ? 32'h0000_ffff : 32'hffff_ffff;
  endfunction

  // Low k bits of x, zero or sign extended to the element
  function automatic vlane_data_pkg::elem_t ext_bits(input vlane_data_pkg::elem_t x,
                                                     input int k, input logic sgn);
    logic [63:0] low;
    low = (64'd1 << k) - 64'd1;
    if (sgn && x[k-1]) return x | ~low[31:0];
    return x & low[31:0];
  endfunction

  function automatic logic is_reduction(input vlane_op_pkg::vop_t op);
    return op inside {vlane_op_pkg::VOP_REDSUM, vlane_op_pkg::VOP_REDMAX,
                      vlane_op_pkg::VOP_REDMIN, vlane_op_pkg::VOP_REDAND,
                      vlane_op_pkg::VOP_REDOR, vlane_op_pkg::VOP_REDXOR};
  endfunction

  // Model of one element; raw is the unmasked result that feeds the accumulator
  function automatic vlane_data_pkg::elem_t expected_out(
      input vlane_op_pkg::vop_t op, input vlane_op_pkg::sew_t s, input logic v,
      input logic m, input vlane_data_pkg::idx_t idx, input vlane_data_pkg::elem_t vs1,
      input vlane_data_pkg::elem_t vs2, input vlane_data_pkg::elem_t vs3,
      output vlane_data_pkg::elem_t raw);
    vlane_data_pkg::elem_t a, msk, ua, ub;
    logic signed [31:0]    sa, sb;
    int                    w, sh;
    logic                  bit_result;
    logic                  active;
    a = (is_reduction(op) && idx != '0) ? model_acc : vs1;
    msk = lane_mask(s);
    w = 8 << int'(s);
    sh = int'(a) & (w - 1);
    ua = a & msk;
    ub = vs2 & msk;
    sa = ext_bits(a, w, 1'b1);
    sb = ext_bits(vs2, w, 1'b1);
    bit_result = op inside {[vlane_op_pkg::VOP_MSEQ:vlane_op_pkg::VOP_MSGT],
                            vlane_op_pkg::VOP_MADC, vlane_op_pkg::VOP_MSBC};
    case (op)
      vlane_op_pkg::VOP_ADD, vlane_op_pkg::VOP_REDSUM: raw = vs2 + a;
      vlane_op_pkg::VOP_SUB:   raw = vs2 - a;
      vlane_op_pkg::VOP_RSUB:  raw = a - vs2;
      vlane_op_pkg::VOP_AND, vlane_op_pkg::VOP_REDAND: raw = vs2 & a;
      vlane_op_pkg::VOP_OR, vlane_op_pkg::VOP_REDOR:   raw = vs2 | a;
      vlane_op_pkg::VOP_XOR, vlane_op_pkg::VOP_REDXOR: raw = vs2 ^ a;
      vlane_op_pkg::VOP_SLL:   raw = vs2 << sh;
      vlane_op_pkg::VOP_SRL:   raw = ub >> sh;
      vlane_op_pkg::VOP_SRA:   raw = sb >>> sh;
      vlane_op_pkg::VOP_MSEQ:  raw = {31'd0, ub == ua};
      vlane_op_pkg::VOP_MSNE:  raw = {31'd0, ub != ua};
      vlane_op_pkg::VOP_MSLTU: raw = {31'd0, ub < ua};
      vlane_op_pkg::VOP_MSLT:  raw = {31'd0, sb < sa};
      vlane_op_pkg::VOP_MSLEU: raw = {31'd0, ub <= ua};
      vlane_op_pkg::VOP_MSLE:  raw = {31'd0, sb <= sa};
      vlane_op_pkg::VOP_MSGTU: raw = {31'd0, ub > ua};
      vlane_op_pkg::VOP_MSGT:  raw = {31'd0, sb > sa};
      vlane_op_pkg::VOP_MINU:  raw = (ub < ua) ? vs2 : a;
      vlane_op_pkg::VOP_MAXU:  raw = (ub < ua) ? a : vs2;
      vlane_op_pkg::VOP_MIN, vlane_op_pkg::VOP_REDMIN: raw = (sb < sa) ? vs2 : a;
      vlane_op_pkg::VOP_MAX, vlane_op_pkg::VOP_REDMAX: raw = (sb < sa) ? a : vs2;
      vlane_op_pkg::VOP_MERGE: raw = m ? a : vs2;
      vlane_op_pkg::VOP_MV:    raw = a;
      vlane_op_pkg::VOP_ZEXT2: raw = ext_bits(vs2, w / 2, 1'b0);
      vlane_op_pkg::VOP_SEXT2: raw = ext_bits(vs2, w / 2, 1'b1);
      vlane_op_pkg::VOP_ZEXT4: raw = ext_bits(vs2, w / 4, 1'b0);
      vlane_op_pkg::VOP_SEXT4: raw = ext_bits(vs2, w / 4, 1'b1);
      vlane_op_pkg::VOP_ZEXT8: raw = ext_bits(vs2, w / 8, 1'b0);
      vlane_op_pkg::VOP_SEXT8: raw = ext_bits(vs2, w / 8, 1'b1);
      vlane_op_pkg::VOP_ADC:   raw = vs2 + a + {31'd0, m};
      vlane_op_pkg::VOP_SBC:   raw = vs2 - a - {31'd0, m};
      // Carry and borrow out of the full 32-bit operation
      vlane_op_pkg::VOP_MADC:
        raw = {31'd0, ({32'd0, vs2} + {32'd0, a} + {63'd0, m}) > 64'hffff_ffff};
      vlane_op_pkg::VOP_MSBC:
        raw = {31'd0, {32'd0, vs2} < ({32'd0, a} + {63'd0, m})};
      default: raw = '0;
    endcase
    active = v | m | (op inside {vlane_op_pkg::VOP_MERGE, vlane_op_pkg::VOP_ADC,
                                 vlane_op_pkg::VOP_SBC, vlane_op_pkg::VOP_MADC,
                                 vlane_op_pkg::VOP_MSBC});
    if (!active) return vs3;
    return bit_result ? raw : (raw & msk);
  endfunction

  function automatic logic coin();
    return ($urandom() & 1) != 0;
  endfunction

  // Random operand that is sometimes near all ones so carries ripple out
  function automatic vlane_data_pkg::elem_t rnd_operand();
    return ($urandom_range(3, 0) == 0) ? ~vlane_data_pkg::elem_t'($urandom_range(3, 0))
                                       : $urandom();
  endfunction

  // Zero, one, largest positive, most negative and all ones, with noise above SEW
  function automatic vlane_data_pkg::elem_t boundary(input vlane_op_pkg::sew_t s, input int k);
    vlane_data_pkg::elem_t m;
    vlane_data_pkg::elem_t v;
    m = lane_mask(s);
    case (k)
      0: v = '0;
      1: v = 32'd1;
      2: v = m >> 1;
      3: v = (m >> 1) + 32'd1;
      default: v = m;
    endcase
    return v | ($urandom() & ~m);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic send(input vlane_op_pkg::vop_t op, input vlane_op_pkg::sew_t s,
                      input logic v, input logic m, input vlane_data_pkg::idx_t idx,
                      input vlane_data_pkg::elem_t a, input vlane_data_pkg::elem_t b,
                      input vlane_data_pkg::elem_t c);
    vlane_data_pkg::elem_t exp;
    vlane_data_pkg::elem_t raw;
    @(posedge CLK);
    in_valid <= 1'b1;
    vop      <= op;
    sew      <= s;
    vm       <= v;
    mask     <= m;
    index    <= idx;
    vs1_data <= a;
    vs2_data <= b;
    vs3_data <= c;
    exp = expected_out(op, s, v, m, idx, a, b, c, raw);
    if (is_reduction(op)) model_acc = raw;
    exp_data.push_back(exp);
    exp_index.push_back(idx);
    // The DUT takes the element at the next edge
    exp_time.push_back($time + PERIOD);
  endtask

  task automatic idle();
    @(posedge CLK);
    in_valid <= 1'b0;
  endtask

  always @(posedge CLK) begin
    if (nRST && out_valid) begin
      if (exp_data.size() == 0) begin
        $display("Output valid at %0t with no element in flight", $time);
        $display("sim failed");
        $fatal(1, "unexpected output");
      end else begin
        check_value("data", out_data, exp_data.pop_front());
        check_value("index", 32'(out_index), 32'(exp_index.pop_front()));
        check_value("latency", 32'($time - exp_time.pop_front()), `VLANE_DEPTH * PERIOD);
      end
    end
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge CLK);
    $display("Timeout after %0d cycles, %0d results missing", MAX_CYCLES, exp_data.size());
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin
    int len;
    vlane_op_pkg::sew_t rs;
    nRST = 1'b0;
    in_valid = 1'b0;
    vop = vlane_op_pkg::VOP_ADD;
    sew = vlane_op_pkg::SEW8;
    vm = 1'b0;
    mask = 1'b0;
    index = '0;
    vs1_data = '0;
    vs2_data = '0;
    vs3_data = '0;
    model_acc = '0;
    void'($urandom(32'hde8d3558));
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    // Quiet cycles, then a back-to-back burst
    repeat (3) @(posedge CLK);
    for (int i = 0; i < 8; i++)
      send(vlane_op_pkg::VOP_ADD, vlane_op_pkg::SEW32, 1'b1, 1'b0,
           vlane_data_pkg::idx_t'(i), $urandom(), $urandom(), $urandom());
    idle();
    for (int i = 0; i < 300; i++)
      send(alu_ops[$urandom_range(9, 0)], vlane_op_pkg::sew_t'($urandom_range(2, 0)),
           1'b1, coin(), vlane_data_pkg::idx_t'($urandom()), $urandom(), $urandom(),
           $urandom());
    // Every boundary pair for each compare and min/max
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 12; o++)
        for (int i = 0; i < 25; i++)
          send(cmp_ops[o], vlane_op_pkg::sew_t'(s), 1'b1, 1'b0, vlane_data_pkg::idx_t'(i),
               boundary(vlane_op_pkg::sew_t'(s), i % 5),
               boundary(vlane_op_pkg::sew_t'(s), i / 5), $urandom());
    for (int s = 0; s < 3; s++) begin
      for (int i = 0; i < 24; i++)
        send(ext_ops[i % 6], vlane_op_pkg::sew_t'(s), 1'b1, coin(),
             vlane_data_pkg::idx_t'(i), $urandom(), $urandom(), $urandom());
      for (int i = 0; i < 8; i++)
        send(vlane_op_pkg::VOP_MERGE, vlane_op_pkg::sew_t'(s), coin(), i[0],
             vlane_data_pkg::idx_t'(i), $urandom(), $urandom(), $urandom());
      for (int i = 0; i < 32; i++)
        send(carry_ops[i % 4], vlane_op_pkg::sew_t'(s), coin(), i[2],
             vlane_data_pkg::idx_t'(i), rnd_operand(), rnd_operand(), $urandom());
    end
    // With vm low only the mask bit or a merge lets an element write
    for (int i = 0; i < 50; i++)
      send((i < 40) ? alu_ops[$urandom_range(9, 0)] : vlane_op_pkg::VOP_MERGE,
           vlane_op_pkg::sew_t'($urandom_range(2, 0)), 1'b0, coin(),
           vlane_data_pkg::idx_t'(i), $urandom(), $urandom(), $urandom());
    for (int o = 0; o < 6; o++) begin
      for (int q = 0; q < 2; q++) begin
        len = $urandom_range(16, 1);
        rs = vlane_op_pkg::sew_t'($urandom_range(2, 0));
        for (int i = 0; i < len; i++)
          send(red_ops[o], rs, 1'b1, coin(), vlane_data_pkg::idx_t'(i),
               $urandom(), $urandom(), $urandom());
      end
    end
    idle();
    for (int i = 0; i < `VLANE_DEPTH + 2 && exp_data.size() != 0; i++) @(negedge CLK);
    if (exp_data.size() != 0) begin
      $display("%0d expected results never came out", exp_data.size());
      $display("sim failed");
      $fatal(1, "missing results");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
